//--- list.f
+incdir+source
source/mmu_op_pkg.sv
source/vm_pkg.sv
source/mmu_cmd_if.sv
source/mmu_resp_if.sv
source/mmu_decode.sv
source/mmu_dtlb.sv
source/mmu_execute.sv
source/mmu_result.sv
source/mmu_top.sv
verif/mmu_tb.sv

//--- run.sh
#!/bin/sh
# Compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"
verilator --binary --timing -Wno-fatal --top-module mmu_tb -f list.f -o mmu_sim
out=$(./obj_dir/mmu_sim)
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -qx "Test passed"; then
  exit 0
fi
exit 1

//--- source/mmu_cmd_if.sv
`default_nettype none

`include "mmu_defines.svh"

interface mmu_cmd_if;
  import mmu_op_pkg::*;

  logic                     valid;
  mem_op_e                  op;
  logic [`MMU_VTAG_W-1:0]   vtag;
  logic [`MMU_OFFSET_W-1:0] offset;
  logic [`MMU_DATA_W-1:0]   wdata;
  // Pipeline enable, sourced from the response stage
  logic                     advance;

  modport producer (output valid, op, vtag, offset, wdata, input advance);
  modport consumer (input valid, op, vtag, offset, wdata, advance);

endinterface

`default_nettype wire

//--- source/mmu_decode.sv
`default_nettype none

`include "mmu_defines.svh"

module mmu_decode (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  input  wire logic                     cmd_v_i,
  input  wire logic [1:0]               cmd_op_i,
  input  wire logic [`MMU_VTAG_W-1:0]   cmd_vtag_i,
  input  wire logic [`MMU_OFFSET_W-1:0] cmd_offset_i,
  input  wire logic [`MMU_DATA_W-1:0]   cmd_data_i,
  output logic                          cmd_ready_o,
  mmu_cmd_if.producer                   cmd
);
  import mmu_op_pkg::*;

  mem_op_e op_dec;

  always_comb begin
    case (cmd_op_i)
      2'd0:    op_dec = e_op_load;
      2'd1:    op_dec = e_op_store;
      default: op_dec = e_op_illegal;
    endcase
  end

  // Stalls whenever the response stage is blocked
  assign cmd_ready_o = cmd.advance;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      cmd.valid <= 1'b0;
    end else if (cmd.advance) begin
      cmd.valid <= cmd_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (cmd.advance && cmd_v_i) begin
      cmd.op     <= op_dec;
      cmd.vtag   <= cmd_vtag_i;
      cmd.offset <= cmd_offset_i;
      cmd.wdata  <= cmd_data_i;
    end
  end

endmodule

`default_nettype wire

//--- source/mmu_defines.svh
`ifndef MMU_DEFINES_SVH
`define MMU_DEFINES_SVH

// Data path
`define MMU_DATA_W 32

// Page tags and word offset within a page
`define MMU_VTAG_W 8
`define MMU_PTAG_W 8
`define MMU_OFFSET_W 6

`define MMU_TLB_ENTRIES 4

// Domain id sits at the top of the physical tag
`define MMU_DID_W 3
`define MMU_DOMAIN_W 8

// Low 2 ptag bits followed by the offset
`define MMU_MEM_INDEX_W 8

`endif

//--- source/mmu_dtlb.sv
`default_nettype none

`include "mmu_defines.svh"

module mmu_dtlb (
  input  wire logic                   clk_i,
  input  wire logic                   reset_i,
  input  wire logic                   flush_i,
  input  wire logic                   w_v_i,
  input  wire logic [`MMU_VTAG_W-1:0] w_vtag_i,
  input  wire vm_pkg::tlb_entry_t     w_entry_i,
  input  wire logic [`MMU_VTAG_W-1:0] r_vtag_i,
  output logic                        hit_o,
  output vm_pkg::tlb_entry_t          entry_o
);
  import vm_pkg::*;

  localparam int ptr_w = $clog2(`MMU_TLB_ENTRIES);

  logic [`MMU_TLB_ENTRIES-1:0] valid_r;
  logic [`MMU_VTAG_W-1:0]      vtag_r [`MMU_TLB_ENTRIES];
  tlb_entry_t                  entry_r [`MMU_TLB_ENTRIES];
  logic [ptr_w-1:0]            rr_ptr_r;
  logic [ptr_w-1:0]            w_idx;
  logic                        w_match;

  // Fully associative lookup
  always_comb begin
    hit_o   = 1'b0;
    entry_o = '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (valid_r[i] && vtag_r[i] == r_vtag_i) begin
        hit_o   = 1'b1;
        entry_o = entry_r[i];
      end
    end
  end

  // Refill an existing mapping in place, else take the victim slot
  always_comb begin
    w_match = 1'b0;
    w_idx   = rr_ptr_r;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (valid_r[i] && vtag_r[i] == w_vtag_i) begin
        w_match = 1'b1;
        w_idx   = ptr_w'(i);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i || flush_i) begin
      valid_r <= '0;
    end else if (w_v_i) begin
      valid_r[w_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      rr_ptr_r <= '0;
    end else if (w_v_i && !flush_i && !w_match) begin
      rr_ptr_r <= rr_ptr_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (w_v_i && !flush_i) begin
      vtag_r[w_idx]  <= w_vtag_i;
      entry_r[w_idx] <= w_entry_i;
    end
  end

endmodule

`default_nettype wire

//--- source/mmu_execute.sv
`default_nettype none

`include "mmu_defines.svh"

module mmu_execute (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  input  wire logic                     poison_i,
  input  wire logic                     translation_en_i,
  input  wire vm_pkg::priv_mode_e       priv_mode_i,
  input  wire logic                     mstatus_sum_i,
  input  wire logic                     tlb_w_v_i,
  input  wire logic [`MMU_VTAG_W-1:0]   tlb_w_vtag_i,
  input  wire vm_pkg::tlb_entry_t       tlb_w_entry_i,
  input  wire logic                     tlb_flush_i,
  input  wire logic                     domain_w_v_i,
  input  wire logic [`MMU_DOMAIN_W-1:0] domain_i,
  input  wire logic                     sac_w_v_i,
  input  wire logic                     sac_i,
  output logic [`MMU_DOMAIN_W-1:0]      cfg_domain_o,
  output logic                          cfg_sac_o,
  mmu_cmd_if.consumer                   cmd,
  mmu_resp_if.producer                  resp
);
  import mmu_op_pkg::*;
  import vm_pkg::*;

  logic                        tlb_hit;
  tlb_entry_t                  tlb_entry;
  logic [`MMU_PTAG_W-1:0]      ptag;
  logic [`MMU_MEM_INDEX_W-1:0] mem_idx;
  logic                        is_store;
  logic                        miss;
  logic                        priv_fault;
  logic                        page_fault;
  logic                        access_fault;
  exc_code_e                   ecode;
  logic [`MMU_DOMAIN_W-1:0]    domain_r;
  logic                        sac_r;
  logic [`MMU_DATA_W-1:0]      mem [1 << `MMU_MEM_INDEX_W];

  mmu_dtlb dtlb_inst (
    .clk_i     (clk_i),
    .reset_i   (reset_i),
    .flush_i   (tlb_flush_i),
    .w_v_i     (tlb_w_v_i),
    .w_vtag_i  (tlb_w_vtag_i),
    .w_entry_i (tlb_w_entry_i),
    .r_vtag_i  (cmd.vtag),
    .hit_o     (tlb_hit),
    .entry_o   (tlb_entry)
  );

  assign ptag     = translation_en_i ? tlb_entry.ptag : cmd.vtag;
  assign mem_idx  = {ptag[`MMU_MEM_INDEX_W-`MMU_OFFSET_W-1:0], cmd.offset};
  assign is_store = (cmd.op == e_op_store);
  assign miss     = translation_en_i && !tlb_hit && (cmd.op != e_op_illegal);

  assign priv_fault = (priv_mode_i == e_priv_s && !mstatus_sum_i && tlb_entry.u)
                    || (priv_mode_i == e_priv_u && !tlb_entry.u);
  assign page_fault = translation_en_i
                    && (priv_fault || (is_store && !(tlb_entry.w && tlb_entry.d)));

  // Domain disabled, or the SAC window without SAC enabled
  assign access_fault = !domain_r[ptag[`MMU_PTAG_W-1 -: `MMU_DID_W]]
                      || (ptag[`MMU_PTAG_W-1 -: `MMU_DID_W+1] == 1 && !sac_r);

  always_comb begin
    if (cmd.op == e_op_illegal) begin
      ecode = e_exc_illegal;
    end else if (miss) begin
      ecode = e_exc_none;
    end else if (page_fault) begin
      ecode = is_store ? e_exc_store_page_fault : e_exc_load_page_fault;
    end else if (access_fault) begin
      ecode = is_store ? e_exc_store_access_fault : e_exc_load_access_fault;
    end else begin
      ecode = e_exc_none;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      domain_r <= `MMU_DOMAIN_W'(1);
      sac_r    <= 1'b0;
    end else begin
      // Domain 0 can never be turned off
      if (domain_w_v_i) domain_r <= domain_i | `MMU_DOMAIN_W'(1);
      if (sac_w_v_i)    sac_r    <= sac_i;
    end
  end

  assign cfg_domain_o = domain_r;
  assign cfg_sac_o    = sac_r;

  always_ff @(posedge clk_i) begin
    if (cmd.advance && cmd.valid && is_store && ecode == e_exc_none && !miss && !poison_i) begin
      mem[mem_idx] <= cmd.wdata;
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      resp.valid <= 1'b0;
    end else if (cmd.advance) begin
      resp.valid <= cmd.valid && !poison_i;
    end
  end

  // Synchronous read with zero data for stores
  always_ff @(posedge clk_i) begin
    if (cmd.advance) begin
      resp.ecode <= ecode;
      resp.miss  <= miss;
      resp.rdata <= (cmd.op == e_op_load) ? mem[mem_idx] : '0;
    end
  end

endmodule

`default_nettype wire

//--- source/mmu_op_pkg.sv
`default_nettype none

package mmu_op_pkg;

  // Raw codes 2 and 3 both decode to illegal
  typedef enum logic [1:0] {
    e_op_load    = 2'd0,
    e_op_store   = 2'd1,
    e_op_illegal = 2'd2
  } mem_op_e;

  typedef enum logic [2:0] {
    e_exc_none               = 3'd0,
    e_exc_illegal            = 3'd1,
    e_exc_load_page_fault    = 3'd2,
    e_exc_store_page_fault   = 3'd3,
    e_exc_load_access_fault  = 3'd4,
    e_exc_store_access_fault = 3'd5
  } exc_code_e;

endpackage

`default_nettype wire

//--- source/mmu_resp_if.sv
`default_nettype none

`include "mmu_defines.svh"

interface mmu_resp_if;
  import mmu_op_pkg::*;

  logic                   valid;
  exc_code_e              ecode;
  logic                   miss;
  logic [`MMU_DATA_W-1:0] rdata;
  logic                   advance;

  modport producer (output valid, ecode, miss, rdata, input advance);
  modport consumer (input valid, ecode, miss, rdata, output advance);

endinterface

`default_nettype wire

//--- source/mmu_result.sv
`default_nettype none

`include "mmu_defines.svh"

module mmu_result (
  input  wire logic                clk_i,
  input  wire logic                reset_i,
  input  wire logic                resp_ready_i,
  output logic                     resp_v_o,
  output logic [`MMU_DATA_W-1:0]   resp_data_o,
  output logic                     resp_exc_v_o,
  output mmu_op_pkg::exc_code_e    resp_ecode_o,
  output logic                     resp_miss_o,
  mmu_resp_if.consumer             resp
);
  import mmu_op_pkg::*;

  logic                   v_r;
  exc_code_e              ecode_r;
  logic                   miss_r;
  logic [`MMU_DATA_W-1:0] data_r;

  // Whole pipeline stalls only on a pending, unconsumed response
  assign resp.advance = !v_r || resp_ready_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      v_r <= 1'b0;
    end else if (resp.advance) begin
      v_r <= resp.valid;
    end
  end

  always_ff @(posedge clk_i) begin
    if (resp.advance) begin
      ecode_r <= resp.ecode;
      miss_r  <= resp.miss;
      data_r  <= resp.rdata;
    end
  end

  assign resp_v_o     = v_r;
  assign resp_ecode_o = ecode_r;
  assign resp_miss_o  = miss_r;
  assign resp_exc_v_o = (ecode_r != e_exc_none);
  // No data on a fault or a miss
  assign resp_data_o  = (resp_exc_v_o || miss_r) ? '0 : data_r;

endmodule

`default_nettype wire

//--- source/mmu_top.sv
`default_nettype none

`include "mmu_defines.svh"

module mmu_top (
  input  wire logic                     clk_i,
  input  wire logic                     reset_i,
  input  wire logic                     cmd_v_i,
  input  wire logic [1:0]               cmd_op_i,
  input  wire logic [`MMU_VTAG_W-1:0]   cmd_vtag_i,
  input  wire logic [`MMU_OFFSET_W-1:0] cmd_offset_i,
  input  wire logic [`MMU_DATA_W-1:0]   cmd_data_i,
  output logic                          cmd_ready_o,
  input  wire logic                     poison_i,
  input  wire logic                     translation_en_i,
  input  wire vm_pkg::priv_mode_e       priv_mode_i,
  input  wire logic                     mstatus_sum_i,
  input  wire logic                     tlb_w_v_i,
  input  wire logic [`MMU_VTAG_W-1:0]   tlb_w_vtag_i,
  input  wire vm_pkg::tlb_entry_t       tlb_w_entry_i,
  input  wire logic                     tlb_flush_i,
  input  wire logic                     domain_w_v_i,
  input  wire logic [`MMU_DOMAIN_W-1:0] domain_i,
  input  wire logic                     sac_w_v_i,
  input  wire logic                     sac_i,
  output logic [`MMU_DOMAIN_W-1:0]      cfg_domain_o,
  output logic                          cfg_sac_o,
  input  wire logic                     resp_ready_i,
  output logic                          resp_v_o,
  output logic [`MMU_DATA_W-1:0]        resp_data_o,
  output logic                          resp_exc_v_o,
  output mmu_op_pkg::exc_code_e         resp_ecode_o,
  output logic                          resp_miss_o
);

  mmu_cmd_if  cmd_if ();
  mmu_resp_if resp_if ();

  // Stall from the response stage reaches every stage
  assign cmd_if.advance = resp_if.advance;

  mmu_decode decode_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .cmd_v_i      (cmd_v_i),
    .cmd_op_i     (cmd_op_i),
    .cmd_vtag_i   (cmd_vtag_i),
    .cmd_offset_i (cmd_offset_i),
    .cmd_data_i   (cmd_data_i),
    .cmd_ready_o  (cmd_ready_o),
    .cmd          (cmd_if.producer)
  );

  mmu_execute execute_inst (
    .clk_i            (clk_i),
    .reset_i          (reset_i),
    .poison_i         (poison_i),
    .translation_en_i (translation_en_i),
    .priv_mode_i      (priv_mode_i),
    .mstatus_sum_i    (mstatus_sum_i),
    .tlb_w_v_i        (tlb_w_v_i),
    .tlb_w_vtag_i     (tlb_w_vtag_i),
    .tlb_w_entry_i    (tlb_w_entry_i),
    .tlb_flush_i      (tlb_flush_i),
    .domain_w_v_i     (domain_w_v_i),
    .domain_i         (domain_i),
    .sac_w_v_i        (sac_w_v_i),
    .sac_i            (sac_i),
    .cfg_domain_o     (cfg_domain_o),
    .cfg_sac_o        (cfg_sac_o),
    .cmd              (cmd_if.consumer),
    .resp             (resp_if.producer)
  );

  mmu_result result_inst (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .resp_ready_i (resp_ready_i),
    .resp_v_o     (resp_v_o),
    .resp_data_o  (resp_data_o),
    .resp_exc_v_o (resp_exc_v_o),
    .resp_ecode_o (resp_ecode_o),
    .resp_miss_o  (resp_miss_o),
    .resp         (resp_if.consumer)
  );

endmodule

`default_nettype wire

//--- source/vm_pkg.sv
`default_nettype none

`include "mmu_defines.svh"

package vm_pkg;

  // Encoding 2 is reserved
  typedef enum logic [1:0] {
    e_priv_u = 2'd0,
    e_priv_s = 2'd1,
    e_priv_m = 2'd3
  } priv_mode_e;

  // Leaf entry of 11 bits
  typedef struct packed {
    logic [`MMU_PTAG_W-1:0] ptag;
    logic                   u;
    logic                   w;
    logic                   d;
  } tlb_entry_t;

endpackage

`default_nettype wire

//--- verif/mmu_tb.sv
`default_nettype none

`include "mmu_defines.svh"

module mmu_tb;
  import mmu_op_pkg::*;
  import vm_pkg::*;

  localparam logic [31:0] seed = 32'h06f1_37f7;
  localparam int n_fill    = 1 << `MMU_MEM_INDEX_W;
  localparam int n_direct  = 200;
  localparam int n_batch   = 40;
  localparam int n_xlat    = 4 * n_batch + 20;
  localparam int n_access  = 4 * n_batch;
  localparam int n_illegal = 20;
  localparam int n_poison  = 30 + 16;
  localparam int n_stream  = 200;
  localparam int total_cmds = n_fill + n_direct + n_xlat + n_access
                            + n_illegal + n_poison + n_stream;
  // 20 cycles per command plus slack for reset and drains
  localparam int timeout = (total_cmds * 20 + 2000) * 40;

  logic                        clk_i = 1'b0;
  logic                        reset_i;
  logic                        cmd_v_i;
  logic [1:0]                  cmd_op_i;
  logic [`MMU_VTAG_W-1:0]      cmd_vtag_i;
  logic [`MMU_OFFSET_W-1:0]    cmd_offset_i;
  logic [`MMU_DATA_W-1:0]      cmd_data_i;
  logic                        cmd_ready_o;
  logic                        poison_i;
  logic                        translation_en_i;
  priv_mode_e                  priv_mode_i;
  logic                        mstatus_sum_i;
  logic                        tlb_w_v_i;
  logic [`MMU_VTAG_W-1:0]      tlb_w_vtag_i;
  tlb_entry_t                  tlb_w_entry_i;
  logic                        tlb_flush_i;
  logic                        domain_w_v_i;
  logic [`MMU_DOMAIN_W-1:0]    domain_i;
  logic                        sac_w_v_i;
  logic                        sac_i;
  logic [`MMU_DOMAIN_W-1:0]    cfg_domain_o;
  logic                        cfg_sac_o;
  logic                        resp_ready_i = 1'b1;
  logic                        resp_v_o;
  logic [`MMU_DATA_W-1:0]      resp_data_o;
  logic                        resp_exc_v_o;
  exc_code_e                   resp_ecode_o;
  logic                        resp_miss_o;

  // Reference model state
  logic [`MMU_DATA_W-1:0]      mem_m [1 << `MMU_MEM_INDEX_W];
  logic [`MMU_TLB_ENTRIES-1:0] tlb_v_m;
  logic [`MMU_VTAG_W-1:0]      tlb_vtag_m [`MMU_TLB_ENTRIES];
  tlb_entry_t                  tlb_ent_m [`MMU_TLB_ENTRIES];
  int                          rr_m;
  logic [`MMU_DOMAIN_W-1:0]    domain_m;
  logic                        sac_m;
  // Each entry is {miss, ecode, data}
  logic [`MMU_DATA_W+3:0]      exp_q [$];

  logic [31:0] rng_state;
  logic [31:0] bp_state;
  logic        bp_en = 1'b0;
  int          err_count;
  int          errs_at_start;
  int          tests_clean;
  int          tests_bad;

  mmu_top mmu_top_inst (.*);

  always #20 clk_i = ~clk_i;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Mostly loads and stores with the odd illegal code
  function automatic logic [1:0] rand_op(input logic [31:0] r);
    if (r[7:4] == 4'd0) begin
      return {1'b1, r[3]};
    end
    return {1'b0, r[3]};
  endfunction

  task automatic model_cmd(input logic [1:0] op, input logic [`MMU_VTAG_W-1:0] vtag,
                           input logic [`MMU_OFFSET_W-1:0] offset,
                           input logic [`MMU_DATA_W-1:0] data, input logic poison);
    logic                        hit;
    tlb_entry_t                  ent;
    logic [`MMU_PTAG_W-1:0]      ptag;
    logic [`MMU_MEM_INDEX_W-1:0] idx;
    logic                        store;
    logic                        miss;
    logic                        pf;
    logic                        af;
    exc_code_e                   ec;
    logic [`MMU_DATA_W-1:0]      rd;
    hit = 1'b0;
    ent = '0;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (tlb_v_m[i] && tlb_vtag_m[i] == vtag) begin
        hit = 1'b1;
        ent = tlb_ent_m[i];
      end
    end
    store = (op == 2'd1);
    ptag  = translation_en_i ? ent.ptag : vtag;
    idx   = {ptag[1:0], offset};
    miss  = 1'b0;
    ec    = e_exc_none;
    rd    = '0;
    if (op[1]) begin
      ec = e_exc_illegal;
    end else if (translation_en_i && !hit) begin
      miss = 1'b1;
    end else begin
      pf = translation_en_i
         && ((priv_mode_i == e_priv_s && !mstatus_sum_i && ent.u)
             || (priv_mode_i == e_priv_u && !ent.u)
             || (store && (!ent.w || !ent.d)));
      // Domain id in the top 3 tag bits and SAC window at top nibble 1
      af = !domain_m[ptag[7:5]] || (ptag[7:4] == 4'h1 && !sac_m);
      if (pf) begin
        ec = store ? e_exc_store_page_fault : e_exc_load_page_fault;
      end else if (af) begin
        ec = store ? e_exc_store_access_fault : e_exc_load_access_fault;
      end else if (store) begin
        if (!poison) mem_m[idx] = data;
      end else begin
        rd = mem_m[idx];
      end
    end
    if (!poison) begin
      exp_q.push_back({miss, ec, rd});
    end
  endtask

  // Called at a falling edge; returns at the falling edge after acceptance
  task automatic send_cmd(input logic [1:0] op, input logic [`MMU_VTAG_W-1:0] vtag,
                          input logic [`MMU_OFFSET_W-1:0] offset,
                          input logic [`MMU_DATA_W-1:0] data, input logic poison);
    model_cmd(op, vtag, offset, data, poison);
    cmd_v_i      = 1'b1;
    cmd_op_i     = op;
    cmd_vtag_i   = vtag;
    cmd_offset_i = offset;
    cmd_data_i   = data;
    @(posedge clk_i);
    while (!cmd_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    cmd_v_i = 1'b0;
    // Held until the next advancing edge moves this command into execute
    poison_i = poison;
  endtask

  task automatic drain();
    @(posedge clk_i);
    while (!cmd_ready_o) @(posedge clk_i);
    @(negedge clk_i);
    poison_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    repeat (4) @(negedge clk_i);
  endtask

  task automatic write_domain(input logic [`MMU_DOMAIN_W-1:0] d);
    domain_w_v_i = 1'b1;
    domain_i     = d;
    @(negedge clk_i);
    domain_w_v_i = 1'b0;
    domain_m     = {d[`MMU_DOMAIN_W-1:1], 1'b1};
    if (cfg_domain_o !== domain_m) begin
      $display("[FAIL] cfg_domain_o: got 0x%02h, expected 0x%02h", cfg_domain_o, domain_m);
      err_count++;
    end
  endtask

  task automatic write_sac(input logic s);
    sac_w_v_i = 1'b1;
    sac_i     = s;
    @(negedge clk_i);
    sac_w_v_i = 1'b0;
    sac_m     = s;
    if (cfg_sac_o !== sac_m) begin
      $display("[FAIL] cfg_sac_o: got 0x%0h, expected 0x%0h", cfg_sac_o, sac_m);
      err_count++;
    end
  endtask

  task automatic fill_tlb(input logic [`MMU_VTAG_W-1:0] vtag, input tlb_entry_t ent);
    int slot;
    slot = -1;
    for (int i = 0; i < `MMU_TLB_ENTRIES; i++) begin
      if (tlb_v_m[i] && tlb_vtag_m[i] == vtag) slot = i;
    end
    if (slot < 0) begin
      slot = rr_m;
      rr_m = (rr_m + 1) % `MMU_TLB_ENTRIES;
    end
    tlb_v_m[slot]    = 1'b1;
    tlb_vtag_m[slot] = vtag;
    tlb_ent_m[slot]  = ent;
    tlb_w_v_i     = 1'b1;
    tlb_w_vtag_i  = vtag;
    tlb_w_entry_i = ent;
    @(negedge clk_i);
    tlb_w_v_i = 1'b0;
  endtask

  task automatic flush_tlb();
    tlb_flush_i = 1'b1;
    @(negedge clk_i);
    tlb_flush_i = 1'b0;
    tlb_v_m     = '0;
  endtask

  task automatic check_response();
    logic [`MMU_DATA_W+3:0] e;
    if (exp_q.size() == 0) begin
      $display("A response arrived with no command outstanding");
      err_count++;
    end else begin
      e = exp_q.pop_front();
      if (resp_miss_o !== e[`MMU_DATA_W+3]) begin
        $display("[FAIL] resp_miss_o: got 0x%0h, expected 0x%0h", resp_miss_o,
                 e[`MMU_DATA_W+3]);
        err_count++;
      end
      if (resp_ecode_o !== e[`MMU_DATA_W+2:`MMU_DATA_W]) begin
        $display("[FAIL] resp_ecode_o: got 0x%0h, expected 0x%0h", resp_ecode_o,
                 e[`MMU_DATA_W+2:`MMU_DATA_W]);
        err_count++;
      end
      if (resp_exc_v_o !== (e[`MMU_DATA_W+2:`MMU_DATA_W] != 3'd0)) begin
        $display("[FAIL] resp_exc_v_o: got 0x%0h, expected 0x%0h", resp_exc_v_o,
                 e[`MMU_DATA_W+2:`MMU_DATA_W] != 3'd0);
        err_count++;
      end
      if (resp_data_o !== e[`MMU_DATA_W-1:0]) begin
        $display("[FAIL] resp_data_o: got 0x%08h, expected 0x%08h", resp_data_o,
                 e[`MMU_DATA_W-1:0]);
        err_count++;
      end
    end
  endtask

  task automatic report_test(input string name);
    if (err_count == errs_at_start) begin
      tests_clean++;
      $display("[DONE] %s: clean", name);
    end else begin
      tests_bad++;
      $display("[DONE] %s: %0d errors", name, err_count - errs_at_start);
    end
    errs_at_start = err_count;
  endtask

  // Response monitor
  always @(posedge clk_i) begin
    if (!reset_i) begin
      if (resp_v_o && !resp_ready_i && cmd_ready_o) begin
        $display("cmd_ready_o was high while a response was held back");
        err_count++;
      end
      if (resp_v_o && resp_ready_i) begin
        check_response();
      end
    end
  end

  // Random back-pressure from its own xorshift stream
  always @(negedge clk_i) begin
    if (bp_en) begin
      bp_state     = xorshift32(bp_state);
      resp_ready_i = bp_state[3];
    end else begin
      resp_ready_i = 1'b1;
    end
  end

  initial begin
    #(timeout);
    $display("Watchdog expired before all tests completed");
    $display("Test failed");
    $finish;
  end

  initial begin
    logic [31:0] r;
    tlb_entry_t  ent;
    rng_state        = seed;
    bp_state         = ~seed;
    err_count        = 0;
    errs_at_start    = 0;
    tests_clean      = 0;
    tests_bad        = 0;
    tlb_v_m          = '0;
    rr_m             = 0;
    domain_m         = `MMU_DOMAIN_W'(1);
    sac_m            = 1'b0;
    reset_i          = 1'b1;
    cmd_v_i          = 1'b0;
    cmd_op_i         = 2'd0;
    cmd_vtag_i       = '0;
    cmd_offset_i     = '0;
    cmd_data_i       = '0;
    poison_i         = 1'b0;
    translation_en_i = 1'b0;
    priv_mode_i      = e_priv_m;
    mstatus_sum_i    = 1'b0;
    tlb_w_v_i        = 1'b0;
    tlb_w_vtag_i     = '0;
    tlb_w_entry_i    = '0;
    tlb_flush_i      = 1'b0;
    domain_w_v_i     = 1'b0;
    domain_i         = '0;
    sac_w_v_i        = 1'b0;
    sac_i            = 1'b0;
    repeat (16) @(negedge clk_i);
    reset_i = 1'b0;
    @(negedge clk_i);

    if (cmd_ready_o !== 1'b1) begin
      $display("[FAIL] cmd_ready_o: got 0x%0h, expected 0x1", cmd_ready_o);
      err_count++;
    end
    if (resp_v_o !== 1'b0) begin
      $display("[FAIL] resp_v_o: got 0x%0h, expected 0x0", resp_v_o);
      err_count++;
    end
    if (cfg_domain_o !== 8'h01) begin
      $display("[FAIL] cfg_domain_o: got 0x%02h, expected 0x01", cfg_domain_o);
      err_count++;
    end
    if (cfg_sac_o !== 1'b0) begin
      $display("[FAIL] cfg_sac_o: got 0x%0h, expected 0x0", cfg_sac_o);
      err_count++;
    end
    write_domain(8'h00);
    write_sac(1'b1);
    report_test("reset and configuration");

    // Direct mode, every word written once before any load
    write_domain(8'hff);
    for (int k = 0; k < n_fill; k++) begin
      r = next_rand();
      send_cmd(2'd1, {r[5:0], k[7:6]}, k[5:0], next_rand(), 1'b0);
    end
    repeat (n_direct) begin
      r = next_rand();
      send_cmd({1'b0, r[0]}, r[15:8], r[21:16], next_rand(), 1'b0);
    end
    drain();
    report_test("direct mode");

    translation_en_i = 1'b1;
    repeat (4) begin
      repeat (3) begin
        r = next_rand();
        ent.ptag = r[15:8];
        ent.u    = r[16];
        ent.w    = r[17] | r[19];
        ent.d    = r[18] | r[20];
        fill_tlb({5'b01010, r[2:0]}, ent);
      end
      r = next_rand();
      case (r[1:0])
        2'd0:    priv_mode_i = e_priv_u;
        2'd1:    priv_mode_i = e_priv_s;
        default: priv_mode_i = e_priv_m;
      endcase
      mstatus_sum_i = r[2];
      repeat (n_batch) begin
        r = next_rand();
        send_cmd(rand_op(r), {5'b01010, r[10:8]}, r[21:16], next_rand(), 1'b0);
      end
      drain();
    end
    flush_tlb();
    repeat (20) begin
      r = next_rand();
      send_cmd(rand_op(r), {5'b01010, r[10:8]}, r[21:16], next_rand(), 1'b0);
    end
    drain();
    report_test("translation and page faults");

    translation_en_i = 1'b0;
    priv_mode_i      = e_priv_m;
    repeat (4) begin
      r = next_rand();
      write_domain(r[7:0]);
      write_sac(r[8]);
      repeat (n_batch) begin
        r = next_rand();
        send_cmd({1'b0, r[0]}, r[1] ? {4'h1, r[11:8]} : r[23:16], r[29:24],
                 next_rand(), 1'b0);
      end
      drain();
    end
    report_test("access faults");

    write_domain(8'hff);
    write_sac(1'b1);
    repeat (n_illegal) begin
      r = next_rand();
      send_cmd({1'b1, r[0]}, r[15:8], r[21:16], next_rand(), 1'b0);
    end
    // Small address window so the loads below see any poisoned store
    repeat (30) begin
      r = next_rand();
      send_cmd({1'b0, r[0]}, {6'd0, r[2:1]}, {4'd0, r[4:3]}, next_rand(), r[5]);
    end
    for (int k = 0; k < 16; k++) begin
      send_cmd(2'd0, {6'd0, k[3:2]}, {4'd0, k[1:0]}, 32'd0, 1'b0);
    end
    drain();
    report_test("illegal opcodes and poison");

    bp_en = 1'b1;
    repeat (n_stream) begin
      r = next_rand();
      send_cmd(rand_op(r), {5'd0, r[10:8]}, r[21:16], next_rand(), 1'b0);
    end
    drain();
    bp_en = 1'b0;
    report_test("back-pressure");

    $display("Summary: %0d tests clean, %0d tests with errors", tests_clean, tests_bad);
    if (err_count == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
